/* verilog/neoIoPkg.sv */
package neoIoPkg;

	// Zone decode mask
	// A21 to A17 and A0 pick the register, A16 to A1 mirror
	localparam logic [23:0] IO_ZONE_MASK  = 24'h3E0001;

	// Read side
	localparam logic [23:0] ADDR_P1CNT    = 24'h300000;
	// Read gives the DIP bank, write kicks the watchdog
	localparam logic [23:0] ADDR_DIPSW    = 24'h300001;
	localparam logic [23:0] ADDR_STATUS_A = 24'h320001;
	localparam logic [23:0] ADDR_P2CNT    = 24'h340000;
	localparam logic [23:0] ADDR_STATUS_B = 24'h380000;

	// Write side, bit-write zones
	localparam logic [23:0] ADDR_BITW0    = 24'h380001;
	// System latch
	localparam logic [23:0] ADDR_BITW1    = 24'h3A0001;

	// BITW0 subregisters, taken from address bits 6 to 4
	localparam logic [2:0] SUB_POUTPUT    = 3'b000;
	localparam logic [2:0] SUB_CRDBANK    = 3'b001;
	localparam logic [2:0] SUB_SLOT       = 3'b010;
	localparam logic [2:0] SUB_LEDLATCHES = 3'b011;
	localparam logic [2:0] SUB_LEDDATA    = 3'b100;
	localparam logic [2:0] SUB_RTCCTRL    = 3'b101;
	// Counter and lockout bits live at 11x
	localparam logic [1:0] SUB_COUNTER_HI = 2'b11;

	// Number of cartridge slots on the board
	localparam int SLOT_COUNT = 6;

	// Cycles without a kick before the watchdog fires
	localparam int WDOG_CYCLES = 2048;
	localparam int WDOG_CNT_W  = $clog2(WDOG_CYCLES);

	// One access from the APB front end to both decoders
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [23:0] addr;
		logic [7:0]  wdata;
	} ioReq_t;

	// Reply from one decoder
	typedef struct packed {
		logic       hit;
		logic [7:0] rdata;
	} ioRsp_t;

	// Listed MSB first, so select 0 lands on bit 0
	typedef struct packed {
		logic palBank;
		logic sramLock;
		logic systemN;
		logic regEnN;
		logic cardWeB;
		logic cardWeN;
		logic vecSel;
		logic shadow;
	} sysLatch_t;

	// Everything the output side drives onto the board
	typedef struct packed {
		logic [2:0] p1Out;
		logic [2:0] p2Out;
		logic [2:0] cardBank;
		logic [5:0] slotN;
		logic [7:0] ledOut1;
		logic [7:0] ledOut2;
		logic [2:0] rtcCtrl;
		logic [1:0] coinCounter;
		logic [1:0] lockout;
	} ioPins_t;

	// True when addr falls on the register at base, any mirror
	function automatic logic regMatch(input logic [23:0] addr, input logic [23:0] base);
		return (addr & IO_ZONE_MASK) == base;
	endfunction

endpackage

/* verilog/ioApbFront.sv */
module ioApbFront (
	input  logic             clk24M,
	input  logic             rst,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  logic [23:0]      paddr,
	input  logic [7:0]       pwdata,
	output logic [7:0]       prdata,
	output logic             pready,
	output logic             pslverr,
	output neoIoPkg::ioReq_t req,
	input  neoIoPkg::ioRsp_t rspIn,
	input  neoIoPkg::ioRsp_t rspOut
);
	import neoIoPkg::*;

	logic setupPhase;
	logic accessQ;
	logic writeQ;
	logic [23:0] addrQ;
	logic [7:0] wdataQ;
	ioRsp_t rspAll;

	// Setup is psel without penable
	assign setupPhase = psel & ~penable;

	// Transfer fields, captured on the setup edge
	always_ff @(posedge clk24M) begin
		if (setupPhase) begin
			addrQ <= paddr;
			writeQ <= pwrite;
			wdataQ <= pwdata;
		end
	end

	// High for the one access cycle that follows setup
	always_ff @(posedge clk24M) begin
		if (rst)
			accessQ <= 1'b0;
		else
			accessQ <= setupPhase;
	end

	// Same request fans out to both decoders
	assign req = '{valid: accessQ, write: writeQ, addr: addrQ, wdata: wdataQ};

	// Non-hitting decoder returns zeros, so OR merges cleanly
	assign rspAll = '{hit: rspIn.hit | rspOut.hit, rdata: rspIn.rdata | rspOut.rdata};

	assign prdata = rspAll.rdata;
	// Zero wait states
	assign pready = accessQ;
	// Nobody claimed the access
	assign pslverr = accessQ & ~rspAll.hit;

	// Access phase only ever follows a setup phase with psel kept high
	assert property (@(posedge clk24M) disable iff (rst)
		penable |-> psel && $past(psel && !penable));

endmodule

/* verilog/ioInputPorts.sv */
module ioInputPorts (
	input  logic             clk24M,
	input  logic             rst,
	input  logic [9:0]       p1In,
	input  logic [9:0]       p2In,
	input  logic [7:0]       dipSw,
	input  logic             testBtn,
	input  neoIoPkg::ioReq_t req,
	output neoIoPkg::ioRsp_t rsp,
	output logic             wdogReset
);
	import neoIoPkg::*;

	// All board inputs, moved as one word through the synchronizer
	typedef struct packed {
		logic [9:0] p1;
		logic [9:0] p2;
		logic [7:0] dip;
		logic       test;
	} pinIn_t;

	pinIn_t pinRaw;
	pinIn_t syncMeta;
	pinIn_t syncQ;
	logic isRead;
	logic kick;
	logic rdHit;
	logic [7:0] rdSel;
	logic [WDOG_CNT_W-1:0] wdogCnt;
	logic wdogExpire;
	logic wdogFlag;

	assign pinRaw = '{p1: p1In, p2: p2In, dip: dipSw, test: testBtn};

	// Two stages, pins are asynchronous to clk24M
	always_ff @(posedge clk24M) begin
		syncMeta <= pinRaw;
		syncQ <= syncMeta;
	end

	assign isRead = req.valid & ~req.write;
	// Only DIPSW is writable here
	assign kick = req.valid & req.write & regMatch(req.addr, ADDR_DIPSW);

	// Read mux, every register reads back active low
	always_comb begin
		rdHit = 1'b0;
		rdSel = 8'h00;
		if (isRead) begin
			if (regMatch(req.addr, ADDR_P1CNT)) begin
				rdHit = 1'b1;
				rdSel = ~syncQ.p1[7:0];
			end else if (regMatch(req.addr, ADDR_P2CNT)) begin
				rdHit = 1'b1;
				rdSel = ~syncQ.p2[7:0];
			end else if (regMatch(req.addr, ADDR_DIPSW)) begin
				rdHit = 1'b1;
				rdSel = ~syncQ.dip;
			end else if (regMatch(req.addr, ADDR_STATUS_B)) begin
				rdHit = 1'b1;
				// Bits 6 to 4 float high on the board
				rdSel = {~syncQ.test, 3'b111, ~syncQ.p2[9], ~syncQ.p2[8],
					~syncQ.p1[9], ~syncQ.p1[8]};
			end else if (regMatch(req.addr, ADDR_STATUS_A)) begin
				rdHit = 1'b1;
				rdSel = {7'b0, wdogFlag};
			end
		end
	end

	assign rsp = '{hit: rdHit | kick, rdata: rdSel};

	assign wdogExpire = (wdogCnt == WDOG_CNT_W'(WDOG_CYCLES - 1));

	// Watchdog, restarts after firing so it keeps pulsing while ignored
	always_ff @(posedge clk24M) begin
		if (rst) begin
			wdogCnt <= '0;
			wdogReset <= 1'b0;
			wdogFlag <= 1'b0;
		end else begin
			wdogReset <= 1'b0;
			if (kick) begin
				wdogCnt <= '0;
				wdogFlag <= 1'b0;
			end else if (wdogExpire) begin
				wdogCnt <= '0;
				wdogReset <= 1'b1;
				// Sticky until the next kick
				wdogFlag <= 1'b1;
			end else begin
				wdogCnt <= wdogCnt + 1'b1;
			end
		end
	end

	// No reply unless the front end is in an access cycle
	assert property (@(posedge clk24M) disable iff (rst) !req.valid |-> !rsp.hit);

endmodule

/* verilog/ioOutputLatches.sv */
module ioOutputLatches (
	input  logic                clk24M,
	input  logic                rst,
	input  neoIoPkg::ioReq_t    req,
	output neoIoPkg::ioRsp_t    rsp,
	output neoIoPkg::ioPins_t   pins,
	output neoIoPkg::sysLatch_t sysLatch
);
	import neoIoPkg::*;

	logic wrBitw0;
	logic wrBitw1;
	logic [2:0] sub;
	logic cntSel;
	logic [7:0] ledData;
	logic [1:0] ledPrev;
	logic [7:0] sysBits;
	logic [5:0] slotNext;

	assign wrBitw0 = req.valid & req.write & regMatch(req.addr, ADDR_BITW0);
	assign wrBitw1 = req.valid & req.write & regMatch(req.addr, ADDR_BITW1);

	// Subregister within BITW0
	assign sub = req.addr[6:4];
	assign cntSel = (sub[2:1] == SUB_COUNTER_HI);

	// One-hot low slot select, out of range deselects all
	always_comb begin
		slotNext = '1;
		if (req.wdata[2:0] < 3'(SLOT_COUNT))
			slotNext[req.wdata[2:0]] = 1'b0;
	end

	always_ff @(posedge clk24M) begin
		if (rst) begin
			pins <= '0;
			// No slot selected
			pins.slotN <= '1;
			ledData <= 8'h00;
			ledPrev <= 2'b00;
		end else if (wrBitw0) begin
			if (cntSel) begin
				// Address bit 4 is the value, bits 2:1 pick the output
				case (req.addr[2:1])
					2'd0: pins.coinCounter[0] <= req.addr[4];
					2'd1: pins.coinCounter[1] <= req.addr[4];
					2'd2: pins.lockout[0] <= req.addr[4];
					default: pins.lockout[1] <= req.addr[4];
				endcase
			end else begin
				case (sub)
					SUB_POUTPUT: begin
						pins.p1Out <= req.wdata[2:0];
						pins.p2Out <= req.wdata[5:3];
					end
					SUB_CRDBANK: pins.cardBank <= req.wdata[2:0];
					SUB_SLOT: pins.slotN <= slotNext;
					SUB_LEDLATCHES: begin
						// Rising edge on bit 4 or 5 latches the LED data
						if (req.wdata[4] & ~ledPrev[0])
							pins.ledOut1 <= ledData;
						if (req.wdata[5] & ~ledPrev[1])
							pins.ledOut2 <= ledData;
						ledPrev <= req.wdata[5:4];
					end
					SUB_LEDDATA: ledData <= req.wdata;
					SUB_RTCCTRL: pins.rtcCtrl <= req.wdata[2:0];
					default: ;
				endcase
			end
		end
	end

	// System latch, address bits 3:1 pick the flag, bit 4 is its value
	always_ff @(posedge clk24M) begin
		if (rst)
			sysBits <= 8'h00;
		else if (wrBitw1)
			sysBits[req.addr[3:1]] <= req.addr[4];
	end

	assign sysLatch = sysLatch_t'(sysBits);

	// Write-only block, never drives read data
	assign rsp = '{hit: wrBitw0 | wrBitw1, rdata: 8'h00};

	// At most one slot enabled at a time
	assert property (@(posedge clk24M) disable iff (rst) $countones(~pins.slotN) <= 1);

endmodule

/* verilog/neoIoTop.sv */
module neoIoTop (
	input  logic                clk24M,
	input  logic                rst,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [23:0]         paddr,
	input  logic [7:0]          pwdata,
	output logic [7:0]          prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic [9:0]          p1In,
	input  logic [9:0]          p2In,
	input  logic [7:0]          dipSw,
	input  logic                testBtn,
	output neoIoPkg::ioPins_t   pins,
	output neoIoPkg::sysLatch_t sysLatch,
	output logic                wdogReset
);
	import neoIoPkg::*;

	// Shared request, one reply per decoder
	ioReq_t req;
	ioRsp_t rspIn;
	ioRsp_t rspOut;

	// CPU-facing APB slave
	ioApbFront ioApbFront_i (
		.clk24M(clk24M), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.req(req), .rspIn(rspIn), .rspOut(rspOut)
	);

	// Joypads, DIPs, status and watchdog
	ioInputPorts ioInputPorts_i (
		.clk24M(clk24M), .rst(rst),
		.p1In(p1In), .p2In(p2In), .dipSw(dipSw), .testBtn(testBtn),
		.req(req), .rsp(rspIn), .wdogReset(wdogReset)
	);

	// Bit-write latches, counters and system latch
	ioOutputLatches ioOutputLatches_i (
		.clk24M(clk24M), .rst(rst),
		.req(req), .rsp(rspOut),
		.pins(pins), .sysLatch(sysLatch)
	);

endmodule

/* sim/clkGen.sv */
module clkGen (
	output logic clk24M,
	output logic rst
);

	// 40-unit period
	initial begin
		clk24M = 1'b0;
		forever #20 clk24M = ~clk24M;
	end

	// Reset held over the first three rising edges
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk24M);
		#5 rst = 1'b0;
	end

endmodule

/* sim/neoIoTb.sv */
module neoIoTb;
	import neoIoPkg::*;

	localparam int ROUNDS_RD = 20;
	localparam int N_BITW = 200;
	localparam int N_CNT = 100;
	localparam int N_ERR = 20;
	localparam int N_TIMING = 20;
	localparam int N_KICKS = 4;
	localparam int KICK_GAP = 1000;
	// One APB transfer plus its idle cycle
	localparam int XFER = 3;
	localparam int TEST_CYCLES = 10 + ROUNDS_RD * (5 + 4 * XFER)
		+ (N_BITW + N_CNT + N_ERR + N_TIMING) * XFER
		+ N_KICKS * (KICK_GAP + 2 * XFER) + WDOG_CYCLES + 10 + 4 * XFER;
	localparam int MARGIN = 500;

	logic clk24M;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [23:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic [7:0] dipSw;
	logic testBtn;
	ioPins_t pins;
	sysLatch_t sysLatch;
	logic wdogReset;

	// Reference model state
	ioPins_t mPins;
	logic [7:0] mSys;
	logic [7:0] mLedData;
	logic [1:0] mLedPrev;
	logic mWdogFlag;

	// Response of the last transfer
	logic [7:0] xRd;
	logic xReady;
	logic xErr;
	logic xSetup;

	integer seed;
	int errCount;
	int testsPassed;
	int testsFailed;
	int pulseCount = 0;

	clkGen clkGen_i (.clk24M(clk24M), .rst(rst));

	neoIoTop neoIoTop_i (
		.clk24M(clk24M), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.p1In(p1In), .p2In(p2In), .dipSw(dipSw), .testBtn(testBtn),
		.pins(pins), .sysLatch(sysLatch), .wdogReset(wdogReset)
	);

	// Counts high cycles of the watchdog output
	always @(negedge clk24M) begin
		if (!rst && wdogReset)
			pulseCount++;
	end

	// Sets address bits 16 to 1 at random to pick a mirror
	function automatic logic [23:0] mirrorOf(input logic [23:0] base);
		return base | (24'($random(seed)) & 24'h01FFFE);
	endfunction

	task automatic compareVal(input string name, input logic [63:0] expVal,
			input logic [63:0] actVal);
		assert (actVal === expVal)
		else begin
			$display("** Error %s: expected %0h, actual %0h", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name);
		if (errCount == 0) begin
			testsPassed++;
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: %0d errors", name, errCount);
		end
		errCount = 0;
	endtask

	// Setup and access cycles followed by a return to idle
	task automatic apbXfer(input logic wr, input logic [23:0] addr, input logic [7:0] data);
		@(posedge clk24M);
		#5;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		#10;
		xSetup = pready;
		@(posedge clk24M);
		#5;
		penable = 1'b1;
		// Reply is already there mid access cycle with zero wait states
		#10;
		xRd = prdata;
		xReady = pready;
		xErr = pslverr;
		@(posedge clk24M);
		#5;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// BITW0 rules with the subregister in address bits 6 to 4
	task automatic applyBitw0(input logic [23:0] addr, input logic [7:0] data);
		logic [2:0] idx;
		idx = data[2:0];
		if (addr[6:5] == 2'b11) begin
			// Counter bits take their value from address bit 4
			case (addr[2:1])
				2'd0: mPins.coinCounter[0] = addr[4];
				2'd1: mPins.coinCounter[1] = addr[4];
				2'd2: mPins.lockout[0] = addr[4];
				default: mPins.lockout[1] = addr[4];
			endcase
		end else begin
			case (addr[6:4])
				3'd0: begin
					mPins.p1Out = data[2:0];
					mPins.p2Out = data[5:3];
				end
				3'd1: mPins.cardBank = data[2:0];
				3'd2: begin
					mPins.slotN = 6'h3F;
					if (idx < 3'd6)
						mPins.slotN[idx] = 1'b0;
				end
				3'd3: begin
					// LED outputs latch on a rising data bit
					if (data[4] && !mLedPrev[0])
						mPins.ledOut1 = mLedData;
					if (data[5] && !mLedPrev[1])
						mPins.ledOut2 = mLedData;
					mLedPrev = data[5:4];
				end
				3'd4: mLedData = data;
				default: mPins.rtcCtrl = data[2:0];
			endcase
		end
	endtask

	task automatic readRegisters();
		logic [7:0] expRd;
		for (int r = 0; r < ROUNDS_RD; r++) begin
			@(posedge clk24M);
			#5;
			p1In = 10'($random(seed));
			p2In = 10'($random(seed));
			dipSw = 8'($random(seed));
			testBtn = 1'($random(seed));
			// Past both synchronizer stages
			repeat (4) @(posedge clk24M);
			apbXfer(1'b0, mirrorOf(ADDR_P1CNT), 8'h00);
			expRd = ~p1In[7:0];
			compareVal("P1CNT read", 64'(expRd), 64'(xRd));
			apbXfer(1'b0, mirrorOf(ADDR_P2CNT), 8'h00);
			expRd = ~p2In[7:0];
			compareVal("P2CNT read", 64'(expRd), 64'(xRd));
			apbXfer(1'b0, mirrorOf(ADDR_DIPSW), 8'h00);
			expRd = ~dipSw;
			compareVal("DIPSW read", 64'(expRd), 64'(xRd));
			apbXfer(1'b0, mirrorOf(ADDR_STATUS_B), 8'h00);
			expRd = {~testBtn, 3'b111, ~p2In[9], ~p2In[8], ~p1In[9], ~p1In[8]};
			compareVal("STATUS_B read", 64'(expRd), 64'(xRd));
		end
		reportTest("read registers");
	endtask

	task automatic bitWriteLatches();
		logic [23:0] addr;
		logic [7:0] data;
		compareVal("reset pins", 64'(mPins), 64'(pins));
		compareVal("reset sysLatch", 64'(mSys), 64'(sysLatch));
		for (int i = 0; i < N_BITW; i++) begin
			addr = mirrorOf(ADDR_BITW0);
			data = 8'($random(seed));
			apbXfer(1'b1, addr, data);
			applyBitw0(addr, data);
			compareVal("bit-write pslverr", 64'(1'b0), 64'(xErr));
			compareVal("bit-write pins", 64'(mPins), 64'(pins));
		end
		reportTest("bit-write latches");
	endtask

	task automatic counterLatches();
		logic [23:0] addr;
		for (int i = 0; i < N_CNT; i++) begin
			if (1'($random(seed))) begin
				// Force the 11x counter subregister
				addr = mirrorOf(ADDR_BITW0) | 24'h000060;
				apbXfer(1'b1, addr, 8'($random(seed)));
				applyBitw0(addr, 8'h00);
			end else begin
				addr = mirrorOf(ADDR_BITW1);
				apbXfer(1'b1, addr, 8'($random(seed)));
				mSys[addr[3:1]] = addr[4];
			end
			compareVal("coinCounter", 64'(mPins.coinCounter), 64'(pins.coinCounter));
			compareVal("lockout", 64'(mPins.lockout), 64'(pins.lockout));
			compareVal("sysLatch", 64'(mSys), 64'(sysLatch));
		end
		reportTest("counters and system latch");
	endtask

	task automatic errorResponses();
		logic [23:0] errBase [10];
		logic [9:0] errWr;
		int c;
		// Read-only and write-only registers followed by unmapped and out-of-zone addresses
		errBase = '{ADDR_P1CNT, ADDR_P2CNT, ADDR_STATUS_A, ADDR_STATUS_B, ADDR_BITW0,
			ADDR_BITW1, 24'h360001, 24'h3C0000, 24'h200000, 24'h000001};
		errWr = 10'b1010001111;
		for (int i = 0; i < N_ERR; i++) begin
			c = i % 10;
			apbXfer(errWr[c], mirrorOf(errBase[c]), 8'($random(seed)));
			compareVal("error pready", 64'(1'b1), 64'(xReady));
			compareVal("error pslverr", 64'(1'b1), 64'(xErr));
			compareVal("error pins", 64'(mPins), 64'(pins));
			compareVal("error sysLatch", 64'(mSys), 64'(sysLatch));
		end
		reportTest("error responses");
	endtask

	task automatic watchdogKicks();
		int startPulses;
		for (int k = 0; k < N_KICKS; k++) begin
			apbXfer(1'b1, mirrorOf(ADDR_DIPSW), 8'($random(seed)));
			mWdogFlag = 1'b0;
			compareVal("kick pslverr", 64'(1'b0), 64'(xErr));
			startPulses = pulseCount;
			repeat (KICK_GAP) @(posedge clk24M);
			apbXfer(1'b0, mirrorOf(ADDR_STATUS_A), 8'h00);
			compareVal("kicked wdogReset pulses", 64'(0), 64'(pulseCount - startPulses));
			compareVal("kicked STATUS_A", 64'({7'b0, mWdogFlag}), 64'(xRd));
		end
		// One kick, then starved just past one watchdog period
		apbXfer(1'b1, mirrorOf(ADDR_DIPSW), 8'($random(seed)));
		mWdogFlag = 1'b0;
		startPulses = pulseCount;
		repeat (WDOG_CYCLES - 10) @(posedge clk24M);
		compareVal("early wdogReset pulses", 64'(0), 64'(pulseCount - startPulses));
		repeat (20) @(posedge clk24M);
		mWdogFlag = 1'b1;
		compareVal("starved wdogReset pulses", 64'(1), 64'(pulseCount - startPulses));
		apbXfer(1'b0, mirrorOf(ADDR_STATUS_A), 8'h00);
		compareVal("expired STATUS_A", 64'({7'b0, mWdogFlag}), 64'(xRd));
		// Next kick clears the sticky flag
		apbXfer(1'b1, mirrorOf(ADDR_DIPSW), 8'h00);
		mWdogFlag = 1'b0;
		apbXfer(1'b0, mirrorOf(ADDR_STATUS_A), 8'h00);
		compareVal("cleared STATUS_A", 64'({7'b0, mWdogFlag}), 64'(xRd));
		reportTest("watchdog");
	endtask

	task automatic apbTiming();
		logic [23:0] addr;
		logic [7:0] expRd;
		for (int i = 0; i < N_TIMING; i++) begin
			if (1'($random(seed))) begin
				apbXfer(1'b0, mirrorOf(ADDR_DIPSW), 8'h00);
				expRd = ~dipSw;
				compareVal("access prdata", 64'(expRd), 64'(xRd));
			end else begin
				addr = mirrorOf(ADDR_BITW1);
				apbXfer(1'b1, addr, 8'h00);
				mSys[addr[3:1]] = addr[4];
				compareVal("access sysLatch", 64'(mSys), 64'(sysLatch));
			end
			// pready only in the access cycle
			compareVal("setup pready", 64'(1'b0), 64'(xSetup));
			compareVal("access pready", 64'(1'b1), 64'(xReady));
			compareVal("access pslverr", 64'(1'b0), 64'(xErr));
		end
		reportTest("APB timing");
	endtask

	initial begin
		seed = 32'haed9_2df7;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 24'h000000;
		pwdata = 8'h00;
		p1In = 10'h000;
		p2In = 10'h000;
		dipSw = 8'h00;
		testBtn = 1'b0;
		// Model reset state with no slot selected
		mPins = '0;
		mPins.slotN = 6'h3F;
		mSys = 8'h00;
		mLedData = 8'h00;
		mLedPrev = 2'b00;
		mWdogFlag = 1'b0;
		errCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		@(negedge rst);
		readRegisters();
		bitWriteLatches();
		counterLatches();
		errorResponses();
		watchdogKicks();
		apbTiming();
		$display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Ends a run that stalls past the expected length
	initial begin
		#((TEST_CYCLES + MARGIN) * 40);
		$display("Timeout: tests did not complete within %0d cycles", TEST_CYCLES + MARGIN);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* sim.f */
verilog/neoIoPkg.sv
verilog/ioApbFront.sv
verilog/ioInputPorts.sv
verilog/ioOutputLatches.sv
verilog/neoIoTop.sv
sim/clkGen.sv
sim/neoIoTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module neoIoTb -Mdir obj_dir
	out="$$(./obj_dir/VneoIoTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
